//--- sim.f
+incdir+rtl
rtl/dla_pkg.sv
rtl/instr_fetch.sv
rtl/instr_fifo.sv
rtl/dla_ctrl.sv
rtl/line_loader.sv
rtl/mac_array.sv
rtl/dla_top.sv
dv/dla_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench; exit status follows the simulation
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal -f sim.f --top-module dla_tb \
        --Mdir obj_dir -o dla_sim \
    && ./obj_dir/dla_sim \
    || exit 1

//--- dv/dla_tb.sv
`include "dla_params.svh"

module dla_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import dla_pkg::*;

    localparam int IMEM_DEPTH = 256;
    localparam int EXT_DEPTH  = 1 << `DLA_EXT_AW;
    localparam int LW         = `DLA_LANE_W;

    logic      clk = 1'b0;
    logic      i_rst_n;
    logic      i_start;
    ext_addr_t o_instr_addr;
    logic      o_instr_rd_en;
    line_t     i_instr_data;
    ext_addr_t o_feat_addr;
    logic      o_feat_rd_en;
    line_t     i_feat_data;
    ext_addr_t o_wgt_addr;
    logic      o_wgt_rd_en;
    line_t     i_wgt_data;
    acc_t      o_result;
    logic      o_result_valid;
    logic      o_done;

    // external memories
    line_t instr_mem [IMEM_DEPTH];
    line_t feat_mem  [EXT_DEPTH];
    line_t wgt_mem   [EXT_DEPTH];

    // reference copies of the on-chip buffers, kept across programs
    line_t fbuf [`DLA_BUF_DEPTH];
    line_t wbuf [`DLA_BUF_DEPTH];

    acc_t      exp_q[$];         // expected results in order
    ext_addr_t feat_addr_q[$];   // expected feature bus addresses
    ext_addr_t wgt_addr_q[$];
    int        halt_at;          // index of the halt word
    int        instr_rd_cnt;     // reads since the last start
    logic      feat_rd_q;
    logic      wgt_rd_q;
    logic      done_q;

    dla_top dut0 (
        .clk(clk), .i_rst_n(i_rst_n), .i_start(i_start),
        .o_instr_addr(o_instr_addr), .o_instr_rd_en(o_instr_rd_en), .i_instr_data(i_instr_data),
        .o_feat_addr(o_feat_addr), .o_feat_rd_en(o_feat_rd_en), .i_feat_data(i_feat_data),
        .o_wgt_addr(o_wgt_addr), .o_wgt_rd_en(o_wgt_rd_en), .i_wgt_data(i_wgt_data),
        .o_result(o_result), .o_result_valid(o_result_valid), .o_done(o_done)
    );

    always #2 clk = ~clk;   // 4 ns period

    ////////////////////////////////////////
    // reporting
    ////////////////////////////////////////
    task automatic stop_with_error(input string msg);
        $display("error: %s", msg);
        $display("Simulation FAILED");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %s: expected 0x%0h, got 0x%0h", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    ////////////////////////////////////////
    // program generation and model
    ////////////////////////////////////////
    function automatic line_t random_instr();
        int unsigned pick;
        logic [3:0]  op;
        pick = $urandom_range(9, 0);
        case (pick)
            0, 1:       op = LOAD_F;
            2, 3:       op = LOAD_W;
            4, 5, 6, 7: op = COMPUTE;
            8:          op = NOP;
            default:    op = 4'($urandom_range(14, 4));   // undefined, runs as nop
        endcase
        // opcode, line, count, src, shift
        return {op, 4'($urandom), 4'($urandom), 16'($urandom), 4'($urandom)};
    endfunction

    // four signed lane products, summed, then arithmetic shift
    function automatic acc_t dot_scaled(input line_t f, input line_t w, input logic [3:0] sh);
        int sum;
        sum = 0;
        for (int l = 0; l < `DLA_LANES; l++) begin
            sum += int'($signed(f[l*LW +: LW])) * int'($signed(w[l*LW +: LW]));
        end
        return acc_t'(sum >>> sh);
    endfunction

    task automatic build_program(input bit with_init, input int n_body, output int n_words);
        int pc;
        pc = 0;
        if (with_init) begin
            // every buffer line filled once before any compute
            instr_mem[0] = {LOAD_F, 4'd0, 4'd15, 16'($urandom), 4'd0};
            instr_mem[1] = {LOAD_W, 4'd0, 4'd15, 16'($urandom), 4'd0};
            pc = 2;
        end
        for (int k = 0; k < n_body; k++) begin
            instr_mem[pc] = random_instr();
            pc++;
        end
        instr_mem[pc] = {HALT, 28'($urandom)};
        n_words = pc + 1;
        for (int k = n_words; k < IMEM_DEPTH; k++) begin
            instr_mem[k] = $urandom;   // junk past halt
        end
    endtask

    task automatic run_model(input int n_words, output int halt_idx, output int load_sum,
                             output int n_exec);
        logic [3:0]  op;
        logic [3:0]  ln;
        logic [3:0]  cnt;
        logic [15:0] src;
        logic [3:0]  sh;
        ext_addr_t   a;
        line_addr_t  idx;
        int          pc;
        bit          halted;
        load_sum = 0;
        n_exec   = 0;
        halt_idx = n_words - 1;
        pc       = 0;
        halted   = 1'b0;
        while (!halted && pc < n_words) begin
            {op, ln, cnt, src, sh} = instr_mem[pc];   // msb first
            n_exec++;
            if (op == LOAD_F || op == LOAD_W) begin
                for (int i = 0; i <= int'(cnt); i++) begin
                    a   = src + 16'(i);   // 16 bit wrap
                    idx = ln + 4'(i);     // buffer wraps at 16
                    if (op == LOAD_F) begin
                        fbuf[idx] = feat_mem[a];
                        feat_addr_q.push_back(a);
                    end else begin
                        wbuf[idx] = wgt_mem[a];
                        wgt_addr_q.push_back(a);
                    end
                end
                load_sum += int'(cnt) + 1;
            end else if (op == COMPUTE) begin
                exp_q.push_back(dot_scaled(fbuf[ln], wbuf[src[3:0]], sh));   // weight line in src
            end else if (op == HALT) begin
                halt_idx = pc;
                halted   = 1'b1;
            end
            pc++;
        end
    endtask

    ////////////////////////////////////////
    // memory model, data one cycle after read
    ////////////////////////////////////////
    always @(posedge clk) begin
        if (o_instr_rd_en) i_instr_data <= instr_mem[o_instr_addr[7:0]];
        if (o_feat_rd_en)  i_feat_data  <= feat_mem[o_feat_addr];
        if (o_wgt_rd_en)   i_wgt_data   <= wgt_mem[o_wgt_addr];
    end

    // bus and result monitor
    always @(posedge clk) begin
        if (i_rst_n) begin
            if (i_start) begin
                instr_rd_cnt = 0;   // fetch restarts at address 0
            end else if (o_instr_rd_en) begin
                check_eq("o_instr_addr", instr_rd_cnt, {16'b0, o_instr_addr});
                if (instr_rd_cnt > halt_at) stop_with_error("instruction read past the HALT word");
                instr_rd_cnt++;
            end
            if (o_feat_rd_en) begin
                if (feat_addr_q.size() == 0) stop_with_error("feature read with no load pending");
                check_eq("o_feat_addr", {16'b0, feat_addr_q.pop_front()}, {16'b0, o_feat_addr});
            end
            if (o_wgt_rd_en) begin
                if (wgt_addr_q.size() == 0) stop_with_error("weight read with no load pending");
                check_eq("o_wgt_addr", {16'b0, wgt_addr_q.pop_front()}, {16'b0, o_wgt_addr});
            end
            if (o_result_valid) begin
                // an earlier compute may land on the first read cycle only
                if (feat_rd_q || wgt_rd_q) stop_with_error("result pulse while a load was running");
                if (exp_q.size() == 0) stop_with_error("result pulse with no compute outstanding");
                check_eq("o_result", {14'b0, exp_q.pop_front()}, {14'b0, o_result});
            end
            // done rises only once all results are out
            if (o_done && !done_q && exp_q.size() != 0) begin
                stop_with_error("o_done rose with results still outstanding");
            end
            feat_rd_q = o_feat_rd_en;
            wgt_rd_q  = o_wgt_rd_en;
            done_q    = o_done;
        end
    end

    ////////////////////////////////////////
    // program runs
    ////////////////////////////////////////
    task automatic run_program(input int n_words);
        int load_sum;
        int n_exec;
        int limit;
        int cycles;
        bit done_seen;
        run_model(n_words, halt_at, load_sum, n_exec);
        limit = load_sum + 4 * n_exec + 100;
        @(posedge clk);
        i_start <= 1'b1;
        @(posedge clk);
        i_start <= 1'b0;
        cycles    = 0;
        done_seen = 1'b0;
        while (!done_seen) begin
            @(posedge clk);
            cycles++;
            if (o_done) begin
                done_seen = 1'b1;
            end else if (cycles > limit) begin
                stop_with_error($sformatf("timeout, o_done not seen within %0d cycles", limit));
            end
        end
        @(posedge clk);
        check_eq("o_done", 1, o_done);   // held until next start
        check_eq("pending results", 0, exp_q.size());
        check_eq("pending feature reads", 0, feat_addr_q.size());
        check_eq("pending weight reads", 0, wgt_addr_q.size());
        check_eq("instruction reads", halt_at + 1, instr_rd_cnt);
    endtask

    initial begin
        int n_words;
        void'($urandom(32'hc4ddf77a));
        i_rst_n      = 1'b0;
        i_start      = 1'b0;
        i_instr_data = '0;
        i_feat_data  = '0;
        i_wgt_data   = '0;
        halt_at      = 0;
        instr_rd_cnt = 0;
        feat_rd_q    = 1'b0;
        wgt_rd_q     = 1'b0;
        done_q       = 1'b0;
        for (int a = 0; a < EXT_DEPTH; a++) begin
            feat_mem[a] = $urandom;
            wgt_mem[a]  = $urandom;
        end
        repeat (3) @(posedge clk);
        i_rst_n <= 1'b1;
        // quiet outputs before the first start
        repeat (3) begin
            @(posedge clk);
            check_eq("o_instr_rd_en", 0, o_instr_rd_en);
            check_eq("o_feat_rd_en", 0, o_feat_rd_en);
            check_eq("o_wgt_rd_en", 0, o_wgt_rd_en);
            check_eq("o_result_valid", 0, o_result_valid);
            check_eq("o_done", 0, o_done);
        end
        build_program(1'b1, 58, n_words);
        run_program(n_words);
        // restart from DONE with buffers still holding the first program's data
        build_program(1'b0, 40, n_words);
        run_program(n_words);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- rtl/dla_top.sv
module dla_top (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_start,
    // instruction memory
    output dla_pkg::ext_addr_t o_instr_addr,
    output logic               o_instr_rd_en,
    input  dla_pkg::line_t     i_instr_data,
    // feature bus
    output dla_pkg::ext_addr_t o_feat_addr,
    output logic               o_feat_rd_en,
    input  dla_pkg::line_t     i_feat_data,
    // weight bus
    output dla_pkg::ext_addr_t o_wgt_addr,
    output logic               o_wgt_rd_en,
    input  dla_pkg::line_t     i_wgt_data,
    // result
    output dla_pkg::acc_t      o_result,
    output logic               o_result_valid,
    output logic               o_done
);
    import dla_pkg::*;

    logic       fetch_start;
    logic       fifo_wr_en;
    instr_t     fifo_wr_data;
    logic       fifo_afull;
    logic       fifo_rd;
    instr_t     fifo_rd_data;
    logic       fifo_empty;
    logic       feat_start;
    logic       wgt_start;
    logic       feat_done;
    logic       wgt_done;
    load_cmd_t  load_cmd;     // shared by both loaders
    logic       mac_start;
    mac_cmd_t   mac_cmd;
    line_addr_t f_line;
    line_addr_t w_line;
    line_t      f_data;
    line_t      w_data;

    ////////////////////////////////////////
    // instruction path
    ////////////////////////////////////////
    instr_fetch u_fetch (
        .clk(clk), .i_rst_n(i_rst_n), .i_start(fetch_start),
        .i_instr_data(i_instr_data), .i_fifo_afull(fifo_afull),
        .o_instr_addr(o_instr_addr), .o_instr_rd_en(o_instr_rd_en),
        .o_wr_en(fifo_wr_en), .o_wr_data(fifo_wr_data)
    );

    instr_fifo u_fifo (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_wr_en(fifo_wr_en), .i_wr_data(fifo_wr_data),
        .i_rd_en(fifo_rd), .o_rd_data(fifo_rd_data),
        .o_empty(fifo_empty), .o_full(), .o_afull(fifo_afull)   // afull throttles fetch
    );

    dla_ctrl u_ctrl (
        .clk(clk), .i_rst_n(i_rst_n), .i_start(i_start),
        .i_fifo_empty(fifo_empty), .i_instr(fifo_rd_data),
        .i_feat_done(feat_done), .i_wgt_done(wgt_done),
        .o_fetch_start(fetch_start), .o_fifo_rd(fifo_rd),
        .o_feat_start(feat_start), .o_wgt_start(wgt_start), .o_load_cmd(load_cmd),
        .o_mac_start(mac_start), .o_mac_cmd(mac_cmd), .o_done(o_done)
    );

    ////////////////////////////////////////
    // buffers and datapath
    ////////////////////////////////////////
    line_loader feat_loader (
        .clk(clk), .i_rst_n(i_rst_n), .i_start(feat_start), .i_cmd(load_cmd),
        .i_ext_data(i_feat_data), .o_ext_addr(o_feat_addr), .o_ext_rd_en(o_feat_rd_en),
        .o_load_done(feat_done), .i_rd_line(f_line), .o_rd_data(f_data)
    );

    line_loader wgt_loader (
        .clk(clk), .i_rst_n(i_rst_n), .i_start(wgt_start), .i_cmd(load_cmd),
        .i_ext_data(i_wgt_data), .o_ext_addr(o_wgt_addr), .o_ext_rd_en(o_wgt_rd_en),
        .o_load_done(wgt_done), .i_rd_line(w_line), .o_rd_data(w_data)
    );

    mac_array u_mac (
        .clk(clk), .i_rst_n(i_rst_n), .i_start(mac_start), .i_cmd(mac_cmd),
        .o_f_line(f_line), .o_w_line(w_line), .i_f_data(f_data), .i_w_data(w_data),
        .o_result(o_result), .o_result_valid(o_result_valid)
    );

endmodule

//--- rtl/mac_array.sv
`include "dla_params.svh"

module mac_array (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_start,
    input  dla_pkg::mac_cmd_t   i_cmd,
    output dla_pkg::line_addr_t o_f_line,
    output dla_pkg::line_addr_t o_w_line,
    input  dla_pkg::line_t      i_f_data,
    input  dla_pkg::line_t      i_w_data,
    output dla_pkg::acc_t       o_result,
    output logic                o_result_valid
);
    import dla_pkg::*;

    localparam int LW = `DLA_LANE_W;

    acc_t   prod [`DLA_LANES];
    acc_t   sum_d;
    acc_t   sum_q;
    acc_t   result_q;
    logic   v1_q;         // loader data valid
    logic   v2_q;         // sum valid
    logic   v3_q;         // scaled result valid
    shift_t sh1_q;
    shift_t sh2_q;

    // stage 1 drives the buffer indices straight from the command
    assign o_f_line = i_cmd.f_line;
    assign o_w_line = i_cmd.w_line;

    ////////////////////////////////////////
    // lane products and adder tree
    ////////////////////////////////////////
    for (genvar l = 0; l < `DLA_LANES; l++) begin : g_lane
        lane_t f_lane;
        lane_t w_lane;
        assign f_lane  = lane_t'(i_f_data[l*LW +: LW]);
        assign w_lane  = lane_t'(i_w_data[l*LW +: LW]);
        assign prod[l] = acc_t'(f_lane) * acc_t'(w_lane);   // signed
    end

    always_comb begin
        sum_d = '0;
        for (int l = 0; l < `DLA_LANES; l++) begin
            sum_d = sum_d + prod[l];
        end
    end

    // stages 2 and 3 payload
    always_ff @(posedge clk) begin
        sum_q    <= sum_d;
        result_q <= sum_q >>> sh2_q;   // arithmetic scaler
        sh1_q    <= i_cmd.shift;
        sh2_q    <= sh1_q;
    end

    // valid travels with the data
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
            v3_q <= 1'b0;
        end else begin
            v1_q <= i_start;
            v2_q <= v1_q;
            v3_q <= v2_q;
        end
    end

    assign o_result       = result_q;
    assign o_result_valid = v3_q;

endmodule

//--- rtl/line_loader.sv
`include "dla_params.svh"

module line_loader (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_start,
    input  dla_pkg::load_cmd_t  i_cmd,
    input  dla_pkg::line_t      i_ext_data,
    output dla_pkg::ext_addr_t  o_ext_addr,
    output logic                o_ext_rd_en,
    output logic                o_load_done,
    input  dla_pkg::line_addr_t i_rd_line,
    output dla_pkg::line_t      o_rd_data
);
    import dla_pkg::*;

    line_t      line_mem [`DLA_BUF_DEPTH];
    logic       busy_q;       // issuing reads
    count_t     left_q;       // reads left after this one
    ext_addr_t  addr_q;
    logic       pend_q;       // data returns this cycle
    logic       last_q;       // ... and it is the final line
    line_addr_t wr_line_q;    // next buffer line to fill

    assign o_ext_rd_en = busy_q;
    assign o_ext_addr  = addr_q;
    assign o_load_done = pend_q && last_q;   // same cycle as last write

    ////////////////////////////////////////
    // external read sequencing
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            busy_q    <= 1'b0;
            left_q    <= '0;
            addr_q    <= '0;
            pend_q    <= 1'b0;
            last_q    <= 1'b0;
            wr_line_q <= '0;
        end else begin
            pend_q <= busy_q;
            last_q <= busy_q && (left_q == '0);
            if (i_start) begin
                busy_q    <= 1'b1;      // first read next cycle
                left_q    <= i_cmd.count;
                addr_q    <= i_cmd.src;
                wr_line_q <= i_cmd.line;
            end else if (busy_q) begin
                addr_q <= addr_q + 1'b1;
                if (left_q == '0) begin
                    busy_q <= 1'b0;
                end else begin
                    left_q <= left_q - 1'b1;
                end
            end
            if (pend_q) begin
                wr_line_q <= wr_line_q + 1'b1;   // wraps at 16
            end
        end
    end

    // buffer write and registered read port
    always_ff @(posedge clk) begin
        if (pend_q) begin
            line_mem[wr_line_q] <= i_ext_data;
        end
        o_rd_data <= line_mem[i_rd_line];   // one cycle latency
    end

endmodule

//--- rtl/dla_ctrl.sv
module dla_ctrl (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_start,
    input  logic               i_fifo_empty,
    input  dla_pkg::instr_t    i_instr,       // fifo head, valid in EXEC
    input  logic               i_feat_done,
    input  logic               i_wgt_done,
    output logic               o_fetch_start,
    output logic               o_fifo_rd,
    output logic               o_feat_start,
    output logic               o_wgt_start,
    output dla_pkg::load_cmd_t o_load_cmd,
    output logic               o_mac_start,
    output dla_pkg::mac_cmd_t  o_mac_cmd,
    output logic               o_done
);
    import dla_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    ////////////////////////////////////////
    // decode of the instruction fields
    ////////////////////////////////////////
    assign o_load_cmd = '{
        line:  i_instr.line,
        count: i_instr.count,
        src:   i_instr.src
    };

    // weight line rides in the low nibble of src
    assign o_mac_cmd = '{
        f_line: i_instr.line,
        w_line: line_addr_t'(i_instr.src),
        shift:  i_instr.shift
    };

    assign o_done = (state_q == DONE);   // held until restart

    // next state and strobes
    always_comb begin
        state_d       = state_q;
        o_fetch_start = 1'b0;
        o_fifo_rd     = 1'b0;
        o_feat_start  = 1'b0;
        o_wgt_start   = 1'b0;
        o_mac_start   = 1'b0;
        case (state_q)
            IDLE, DONE: begin
                if (i_start) begin
                    o_fetch_start = 1'b1;
                    state_d       = POP;
                end
            end
            POP: begin
                if (!i_fifo_empty) begin
                    o_fifo_rd = 1'b1;   // word shows up next cycle
                    state_d   = EXEC;
                end
            end
            EXEC: begin
                case (i_instr.opcode)
                    LOAD_F: begin
                        o_feat_start = 1'b1;
                        state_d      = WAIT_LOAD;
                    end
                    LOAD_W: begin
                        o_wgt_start = 1'b1;
                        state_d     = WAIT_LOAD;
                    end
                    COMPUTE: begin
                        o_mac_start = 1'b1;   // result 3 cycles on
                        state_d     = POP;
                    end
                    HALT:    state_d = DONE;
                    default: state_d = POP;   // nop and unknown codes
                endcase
            end
            WAIT_LOAD: begin
                // only one loader busy at a time
                if (i_feat_done || i_wgt_done) begin
                    state_d = POP;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

//--- rtl/instr_fifo.sv
`include "dla_params.svh"

module instr_fifo (
    input  logic            clk,
    input  logic            i_rst_n,
    input  logic            i_wr_en,
    input  dla_pkg::instr_t i_wr_data,
    input  logic            i_rd_en,
    output dla_pkg::instr_t o_rd_data,
    output logic            o_empty,
    output logic            o_full,
    output logic            o_afull
);
    import dla_pkg::*;

    localparam int DEPTH = `DLA_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    instr_t        mem [DEPTH];
    logic [AW-1:0] wr_ptr_q;    // wraps, depth is a power of two
    logic [AW-1:0] rd_ptr_q;
    logic [AW:0]   count_q;     // occupancy
    logic          do_wr;
    logic          do_rd;

    assign do_wr = i_wr_en && !o_full;
    assign do_rd = i_rd_en && !o_empty;

    // flags straight off the counter
    assign o_empty = (count_q == '0);
    assign o_full  = (count_q == (AW+1)'(DEPTH));
    assign o_afull = (count_q >= (AW+1)'(DEPTH - 1));   // one slot or less

    ////////////////////////////////////////
    // storage and registered read
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= i_wr_data;
        end
        if (do_rd) begin
            o_rd_data <= mem[rd_ptr_q];   // visible next cycle
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;   // both or neither
            endcase
        end
    end

endmodule

//--- rtl/instr_fetch.sv
module instr_fetch (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_start,       // fetch start from ctrl
    input  dla_pkg::line_t    i_instr_data,
    input  logic              i_fifo_afull,
    output dla_pkg::ext_addr_t o_instr_addr,
    output logic              o_instr_rd_en,
    output logic              o_wr_en,
    output dla_pkg::instr_t   o_wr_data
);
    import dla_pkg::*;

    ext_addr_t addr_q;       // next word to read
    logic      running_q;
    logic      inflight_q;   // word returns this cycle
    instr_t    ret_word;
    logic      halt_seen;

    assign ret_word  = instr_t'(i_instr_data);
    assign halt_seen = inflight_q && (ret_word.opcode == HALT);

    // no read once halt is back, so addresses stop at the halt word
    assign o_instr_rd_en = running_q && !i_fifo_afull && !halt_seen;
    assign o_instr_addr  = addr_q;

    // every returning word goes to the fifo, halt included
    assign o_wr_en   = inflight_q;
    assign o_wr_data = ret_word;

    ////////////////////////////////////////
    // address counter and run flag
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            addr_q     <= '0;
            running_q  <= 1'b0;
            inflight_q <= 1'b0;
        end else begin
            inflight_q <= o_instr_rd_en;   // one cycle read latency
            if (i_start) begin
                addr_q    <= '0;           // program starts at 0
                running_q <= 1'b1;
            end else begin
                if (o_instr_rd_en) begin
                    addr_q <= addr_q + 1'b1;
                end
                if (halt_seen) begin
                    running_q <= 1'b0;     // end of program
                end
            end
        end
    end

endmodule

//--- rtl/dla_pkg.sv
`include "dla_params.svh"

package dla_pkg;

    ////////////////////////////////////////
    // plain vectors
    ////////////////////////////////////////
    typedef logic [`DLA_LINE_W-1:0]        line_t;       // bus word / buffer line
    typedef logic signed [`DLA_LANE_W-1:0] lane_t;       // one feature or weight
    typedef logic [`DLA_EXT_AW-1:0]        ext_addr_t;
    typedef logic [`DLA_IDX_W-1:0]         line_addr_t;  // wraps at 16 lines
    typedef logic signed [`DLA_ACC_W-1:0]  acc_t;
    typedef logic [`DLA_SHIFT_W-1:0]       shift_t;
    typedef logic [`DLA_CNT_W-1:0]         count_t;      // lines minus one

    // undefined codes fall through as nop
    typedef enum logic [`DLA_OP_W-1:0] {
        NOP     = 4'd0,
        LOAD_F  = 4'd1,
        LOAD_W  = 4'd2,
        COMPUTE = 4'd3,
        HALT    = 4'd15
    } opcode_e;

    typedef struct packed {
        opcode_e    opcode;
        line_addr_t line;   // load dest or feature line
        count_t     count;
        ext_addr_t  src;    // low nibble is weight line on compute
        shift_t     shift;
    } instr_t;

    typedef struct packed {
        line_addr_t line;
        count_t     count;
        ext_addr_t  src;
    } load_cmd_t;

    typedef struct packed {
        line_addr_t f_line;
        line_addr_t w_line;
        shift_t     shift;
    } mac_cmd_t;

    typedef enum logic [2:0] {IDLE, POP, EXEC, WAIT_LOAD, DONE} ctrl_state_e;

endpackage

//--- rtl/dla_params.svh
`ifndef DLA_PARAMS_SVH
`define DLA_PARAMS_SVH

// datapath geometry
`define DLA_LANES        4   // lanes per line
`define DLA_LANE_W       8   // bits per feature or weight
`define DLA_LINE_W       32  // bus word and buffer line
`define DLA_ACC_W        18  // dot product width

// storage
`define DLA_BUF_DEPTH    16  // lines per on-chip buffer
`define DLA_FIFO_DEPTH   8   // instruction entries
`define DLA_EXT_AW       16  // external address bits

////////////////////////////////////////
// instruction fields, msb first
////////////////////////////////////////
`define DLA_OP_W         4   // opcode
`define DLA_IDX_W        4   // buffer line index
`define DLA_CNT_W        4   // load length minus one
`define DLA_SHIFT_W      4   // scaler shift amount

`endif
